/* hdl/rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] word_t;     // data, address or instruction
    typedef logic [4:0]  reg_addr_t;

    // result functions first, branch conditions after
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_JALR,  // add, bit 0 cleared
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } alu_op_e;

    typedef enum logic {
        OP1_RS1,
        OP1_PC
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_RS2,
        OP2_IMI,
        OP2_IMS,
        OP2_IMJ,
        OP2_IMU
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC     // link address
    } wb_sel_e;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM
    } seq_state_e;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

endpackage

/* hdl/rv_decoder.sv */
module rv_decoder (
    input  rv_pkg::word_t     inst_i,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output rv_pkg::reg_addr_t rd_o,
    output rv_pkg::word_t     imm_o,
    output rv_pkg::alu_op_e   alu_op_o,
    output rv_pkg::op1_sel_e  op1_sel_o,
    output rv_pkg::op2_sel_e  op2_sel_o,
    output rv_pkg::wb_sel_e   wb_sel_o,
    output logic              rf_wen_o,
    output logic              is_load_o,
    output logic              is_store_o,
    output logic              is_branch_o,
    output logic              is_jump_o,
    output rv_pkg::word_t     br_imm_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;
    logic       op_ok;
    logic       op_imm_ok;
    alu_op_e    alu_fn;
    word_t      imm_i, imm_s, imm_j, imm_u;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i    = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s    = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_j    = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u    = {inst_i[31:12], 12'b0};
    assign br_imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    assign f7_zero   = (funct7 == 7'b0000000);
    assign f7_alt    = (funct7 == 7'b0100000);
    assign op_ok     = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
    assign op_imm_ok = (funct3 == 3'b001) ? f7_zero :
                       (funct3 == 3'b101) ? (f7_zero || f7_alt) : 1'b1;

    // funct3 map shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (opcode == OPC_OP && f7_alt) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_fn = ALU_SLL;
            3'b010:  alu_fn = ALU_SLT;
            3'b011:  alu_fn = ALU_SLTU;
            3'b100:  alu_fn = ALU_XOR;
            3'b101:  alu_fn = f7_alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    end

    always_comb begin
        rs1_o       = inst_i[19:15];
        rs2_o       = inst_i[24:20];
        rd_o        = inst_i[11:7];
        alu_op_o    = ALU_ADD;
        op1_sel_o   = OP1_RS1;
        op2_sel_o   = OP2_RS2;
        wb_sel_o    = WB_ALU;
        rf_wen_o    = 1'b0;   // unknown encodings fall through as no-ops
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        is_jump_o   = 1'b0;
        case (opcode)
            OPC_OP: begin
                rf_wen_o = op_ok;
                alu_op_o = alu_fn;
            end
            OPC_OP_IMM: begin
                rf_wen_o  = op_imm_ok;
                alu_op_o  = alu_fn;
                op2_sel_o = OP2_IMI;
            end
            OPC_LOAD: begin
                op2_sel_o = OP2_IMI;
                wb_sel_o  = WB_MEM;
                is_load_o = (funct3 == 3'b010);  // lw only
                rf_wen_o  = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                op2_sel_o  = OP2_IMS;
                is_store_o = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                is_branch_o = (funct3[2:1] != 2'b01);
                case (funct3)
                    3'b000:  alu_op_o = BR_BEQ;
                    3'b001:  alu_op_o = BR_BNE;
                    3'b100:  alu_op_o = BR_BLT;
                    3'b101:  alu_op_o = BR_BGE;
                    3'b110:  alu_op_o = BR_BLTU;
                    3'b111:  alu_op_o = BR_BGEU;
                    default: alu_op_o = ALU_ADD;
                endcase
            end
            OPC_JAL: begin
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMJ;
                wb_sel_o  = WB_PC;
                rf_wen_o  = 1'b1;
                is_jump_o = 1'b1;
            end
            OPC_JALR: begin
                alu_op_o  = ALU_JALR;
                op2_sel_o = OP2_IMI;
                wb_sel_o  = WB_PC;
                rf_wen_o  = (funct3 == 3'b000);
                is_jump_o = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                rs1_o     = '0;         // x0 + imm_u
                op2_sel_o = OP2_IMU;
                rf_wen_o  = 1'b1;
            end
            OPC_AUIPC: begin
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMU;
                rf_wen_o  = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op2_sel_o)
            OP2_IMI: imm_o = imm_i;
            OP2_IMS: imm_o = imm_s;
            OP2_IMJ: imm_o = imm_j;
            OP2_IMU: imm_o = imm_u;
            default: imm_o = '0;
        endcase
    end

endmodule

/* hdl/rv_regfile.sv */
module rv_regfile #(
    parameter int REG_COUNT = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  rv_pkg::word_t     rd_data_i,
    output rv_pkg::word_t     gp_o
);
    import rv_pkg::*;

    word_t regs [REG_COUNT];

    // indices past the file read as zero, x0 reads its cleared entry
    assign rs1_data_o = (int'(rs1_i) < REG_COUNT) ? regs[rs1_i] : '0;
    assign rs2_data_o = (int'(rs2_i) < REG_COUNT) ? regs[rs2_i] : '0;
    assign gp_o       = regs[3];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0 && int'(rd_i) < REG_COUNT) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // x0 survives every writeback from the core
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n) regs[0] == '0
    );

endmodule

/* hdl/rv_alu.sv */
module rv_alu (
    input  rv_pkg::alu_op_e op_i,
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    output rv_pkg::word_t   result_o,
    output logic            br_taken_o
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;
    word_t      sum;

    assign shamt = b_i[4:0];
    assign eq    = (a_i == b_i);
    assign lt_s  = ($signed(a_i) < $signed(b_i));
    assign lt_u  = (a_i < b_i);
    assign sum   = a_i + b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            ALU_SLT:  result_o = {31'b0, lt_s};
            ALU_SLTU: result_o = {31'b0, lt_u};
            ALU_JALR: result_o = {sum[31:1], 1'b0};
            default:  result_o = '0;  // branch ops produce no result
        endcase
    end

    always_comb begin
        case (op_i)
            BR_BEQ:  br_taken_o = eq;
            BR_BNE:  br_taken_o = !eq;
            BR_BLT:  br_taken_o = lt_s;
            BR_BGE:  br_taken_o = !lt_s;
            BR_BLTU: br_taken_o = lt_u;
            BR_BGEU: br_taken_o = !lt_u;
            default: br_taken_o = 1'b0;
        endcase
    end

endmodule

/* hdl/rv_sequencer.sv */
module rv_sequencer #(
    parameter rv_pkg::word_t RESET_PC  = 32'h0000_0000,
    parameter rv_pkg::word_t EXIT_ADDR = 32'h0000_1000
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          is_load_i,
    input  logic          is_store_i,
    input  logic          is_branch_i,
    input  logic          is_jump_i,
    input  logic          rf_wen_i,
    input  logic          br_taken_i,
    input  rv_pkg::word_t alu_result_i,
    input  rv_pkg::word_t br_imm_i,
    output rv_pkg::word_t pc_o,
    output logic          rf_we_o,
    output logic          dmem_wen_o,
    output logic          exit_o
);
    import rv_pkg::*;

    seq_state_e state;
    word_t      pc;
    word_t      pc_plus4;
    word_t      next_pc;
    logic       mem_access;
    logic       commit;

    assign pc_o       = pc;
    assign exit_o     = (pc == EXIT_ADDR);
    assign pc_plus4   = pc + 32'd4;
    assign mem_access = is_load_i || is_store_i;

    assign next_pc = (is_branch_i && br_taken_i) ? pc + br_imm_i :
                     is_jump_i                   ? alu_result_i :
                                                   pc_plus4;

    // last cycle of the instruction
    assign commit = (state == EXEC && !mem_access) || state == MEM;

    assign rf_we_o    = (state == EXEC && rf_wen_i && !is_load_i)
                     || (state == MEM && rf_wen_i && is_load_i);
    assign dmem_wen_o = (state == MEM) && is_store_i;  // single-cycle strobe

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH;
            pc    <= RESET_PC;
        end else begin
            case (state)
                FETCH: begin
                    if (!exit_o) begin  // parked at exit
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    state <= mem_access ? MEM : FETCH;
                end
                MEM: begin
                    state <= FETCH;
                end
                default: state <= FETCH;
            endcase
            if (commit) begin
                pc <= next_pc;
            end
        end
    end

    // strobe belongs to the store decoded in the EXEC cycle before
    a_wen_in_mem: assert property (
        @(posedge clk) disable iff (!rst_n)
        dmem_wen_o |-> state == MEM && $past(state) == EXEC && $stable(pc)
    );

    a_wen_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) dmem_wen_o |=> !dmem_wen_o
    );

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    );

endmodule

/* hdl/rv_core.sv */
module rv_core #(
    parameter rv_pkg::word_t RESET_PC  = 32'h0000_0000,
    parameter rv_pkg::word_t EXIT_ADDR = 32'h0000_1000,
    parameter int            REG_COUNT = 32
) (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t imem_addr_o,
    input  rv_pkg::word_t imem_inst_i,
    output rv_pkg::word_t dmem_addr_o,
    input  rv_pkg::word_t dmem_rdata_i,
    output rv_pkg::word_t dmem_wdata_o,
    output logic          dmem_wen_o,
    output logic          exit_o,
    output rv_pkg::word_t gp_o
);
    import rv_pkg::*;

    reg_addr_t rs1, rs2, rd;
    word_t     rs1_data, rs2_data;
    word_t     imm, br_imm;
    word_t     pc, pc_plus4;
    word_t     op1, op2;
    word_t     alu_result;
    word_t     wb_data;
    alu_op_e   alu_op;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    wb_sel_e   wb_sel;
    logic      rf_wen, rf_we;
    logic      is_load, is_store, is_branch, is_jump;
    logic      br_taken;

    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign pc_plus4     = pc + 32'd4;

    assign op1 = (op1_sel == OP1_PC) ? pc : rs1_data;
    assign op2 = (op2_sel == OP2_RS2) ? rs2_data : imm;

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = dmem_rdata_i;
            WB_PC:   wb_data = pc_plus4;  // jal/jalr link
            default: wb_data = alu_result;
        endcase
    end

    rv_decoder u_decoder (
        .inst_i(imem_inst_i), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
        .imm_o(imm), .alu_op_o(alu_op), .op1_sel_o(op1_sel), .op2_sel_o(op2_sel),
        .wb_sel_o(wb_sel), .rf_wen_o(rf_wen), .is_load_o(is_load),
        .is_store_o(is_store), .is_branch_o(is_branch), .is_jump_o(is_jump),
        .br_imm_o(br_imm)
    );

    rv_regfile #(.REG_COUNT(REG_COUNT)) u_regfile (
        .clk(clk), .rst_n(rst_n), .rs1_i(rs1), .rs2_i(rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rf_we), .rd_i(rd), .rd_data_i(wb_data), .gp_o(gp_o)
    );

    rv_alu u_alu (
        .op_i(alu_op), .a_i(op1), .b_i(op2),
        .result_o(alu_result), .br_taken_o(br_taken)
    );

    rv_sequencer #(.RESET_PC(RESET_PC), .EXIT_ADDR(EXIT_ADDR)) u_sequencer (
        .clk(clk), .rst_n(rst_n),
        .is_load_i(is_load), .is_store_i(is_store),
        .is_branch_i(is_branch), .is_jump_i(is_jump),
        .rf_wen_i(rf_wen), .br_taken_i(br_taken),
        .alu_result_i(alu_result), .br_imm_i(br_imm),
        .pc_o(pc), .rf_we_o(rf_we), .dmem_wen_o(dmem_wen_o), .exit_o(exit_o)
    );

endmodule

/* test/tb_mem.sv */
module tb_mem (
    input  logic          clk_i,
    input  rv_pkg::word_t imem_addr_i,
    output rv_pkg::word_t imem_inst_o,
    input  rv_pkg::word_t dmem_addr_i,
    output rv_pkg::word_t dmem_rdata_o,
    input  rv_pkg::word_t dmem_wdata_i,
    input  logic          dmem_wen_i,
    input  logic          exp_valid_i,  // a store is expected in this test
    input  rv_pkg::word_t exp_addr_i,
    input  rv_pkg::word_t exp_data_i,
    output int            err_cnt_o,
    output int            strobe_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    word_t mem [2048];  // 8 KiB, word indexed

    initial begin
        err_cnt_o    = 0;
        strobe_cnt_o = 0;
        for (int i = 0; i < 2048; i++) begin
            mem[i] = {16'(i), ~16'(i)};  // address pattern until a program is loaded
        end
    end

    assign imem_inst_o  = mem[imem_addr_i[12:2]];
    assign dmem_rdata_o = mem[dmem_addr_i[12:2]];

    always @(posedge clk_i) begin
        if (dmem_wen_i) begin
            mem[dmem_addr_i[12:2]] <= dmem_wdata_i;
            strobe_cnt_o <= strobe_cnt_o + 1;
            if (!exp_valid_i) begin
                err_cnt_o <= err_cnt_o + 1;
                $display("store strobe seen in a test without a store, address %h", dmem_addr_i);
            end else if (dmem_addr_i !== exp_addr_i) begin
                err_cnt_o <= err_cnt_o + 1;
                $display("Mismatch store_addr: expected %h, actual %h", exp_addr_i, dmem_addr_i);
            end else if (dmem_wdata_i !== exp_data_i) begin
                err_cnt_o <= err_cnt_o + 1;
                $display("Mismatch store_data: expected %h, actual %h", exp_data_i, dmem_wdata_i);
            end
        end
    end

endmodule

/* test/tb_core.sv */
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam word_t EXIT_ADDR = 32'h0000_1000;
    localparam word_t DATA_ADDR = 32'h0000_0600;

    // R kinds first, I kinds in the order AND OR XOR SLL SRL SRA SLT SLTU after ADDI
    localparam int K_ADD = 0, K_SUB = 1, K_AND = 2, K_OR = 3, K_XOR = 4;
    localparam int K_SLL = 5, K_SRL = 6, K_SRA = 7, K_SLT = 8, K_SLTU = 9;
    localparam int K_ADDI = 10, K_ANDI = 11, K_ORI = 12, K_XORI = 13, K_SLLI = 14;
    localparam int K_SRLI = 15, K_SRAI = 16, K_SLTI = 17, K_SLTIU = 18;
    localparam int K_LUI = 19, K_AUIPC = 20, K_BEQ = 21, K_BNE = 22, K_BLT = 23;
    localparam int K_BGE = 24, K_BLTU = 25, K_BGEU = 26, K_SWLW = 27, K_JAL = 28, K_JALR = 29;

    logic        clk;
    logic        rst_n;
    word_t       imem_addr, imem_inst, dmem_addr, dmem_rdata, dmem_wdata, gp;
    logic        dmem_wen, exit_flag;
    logic        exp_valid;
    word_t       exp_addr, exp_data;
    int          mem_errs, strobes;
    string       names [$];
    int          kinds [$];
    bit          rnds [$];
    word_t       opa [$];
    word_t       opb [$];
    int          errors = 0;
    int          n_rows = 0;
    logic [31:0] lfsr = 32'he512_6604;

    rv_core #(.RESET_PC(32'h0), .EXIT_ADDR(EXIT_ADDR), .REG_COUNT(32)) uut (
        .clk(clk), .rst_n(rst_n), .imem_addr_o(imem_addr), .imem_inst_i(imem_inst),
        .dmem_addr_o(dmem_addr), .dmem_rdata_i(dmem_rdata), .dmem_wdata_o(dmem_wdata),
        .dmem_wen_o(dmem_wen), .exit_o(exit_flag), .gp_o(gp)
    );

    tb_mem u_mem (
        .clk_i(clk), .imem_addr_i(imem_addr), .imem_inst_o(imem_inst),
        .dmem_addr_i(dmem_addr), .dmem_rdata_o(dmem_rdata), .dmem_wdata_i(dmem_wdata),
        .dmem_wen_i(dmem_wen), .exp_valid_i(exp_valid), .exp_addr_i(exp_addr),
        .exp_data_i(exp_data), .err_cnt_o(mem_errs), .strobe_cnt_o(strobes)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr, one step per bit
    function automatic word_t rand_word();
        word_t v;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
                                    logic [4:0] rs1, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, logic [2:0] f3, logic [4:0] rs1,
                                    logic [4:0] rs2);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [2:0] f3_of(int k);
        case (k)
            K_AND:         return 3'b111;
            K_OR:          return 3'b110;
            K_XOR:         return 3'b100;
            K_SLL:         return 3'b001;
            K_SRL, K_SRA:  return 3'b101;
            K_SLT:         return 3'b010;
            K_SLTU:        return 3'b011;
            K_BNE:         return 3'b001;
            K_BLT:         return 3'b100;
            K_BGE:         return 3'b101;
            K_BLTU:        return 3'b110;
            K_BGEU:        return 3'b111;
            default:       return 3'b000;  // add, sub, beq
        endcase
    endfunction

    // RV32I result rules, written out bit by bit where it matters
    function automatic word_t alu_ref(int k, word_t a, word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (k)
            K_ADD:   return a + b;
            K_SUB:   return a + ~b + 32'd1;
            K_AND:   return a & b;
            K_OR:    return a | b;
            K_XOR:   return a ^ b;
            K_SLL:   return a << sh;
            K_SRL:   return a >> sh;
            K_SRA:   return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            K_SLT:   return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            default: return {31'b0, a < b};
        endcase
    endfunction

    function automatic bit taken_ref(int k, word_t a, word_t b);
        bit lt_s;
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);
        case (k)
            K_BEQ:   return a == b;
            K_BNE:   return a != b;
            K_BLT:   return lt_s;
            K_BGE:   return !lt_s;
            K_BLTU:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t expect_x3(int k, word_t a, word_t b);
        if (k <= K_SLTU) return alu_ref(k, a, b);
        if (k <= K_SLTIU) return alu_ref((k == K_ADDI) ? K_ADD : k - 9, a, {{20{b[11]}}, b[11:0]});
        case (k)
            K_LUI:   return {b[31:12], 12'b0};
            K_AUIPC: return 32'd16 + {b[31:12], 12'b0};  // auipc sits at 0x10
            K_SWLW:  return b;
            K_JAL, K_JALR: return 32'd20;
            default: return taken_ref(k, a, b) ? 32'd2 : 32'd3;
        endcase
    endfunction

    // x1 = a, x2 = b, instruction under test at 0x10, then jal to exit
    task automatic load_program(int k, word_t a, word_t b);
        word_t prog [$];
        word_t hi;
        word_t off;
        logic [11:0] imm;
        hi = a + 32'h800;
        prog.push_back({hi[31:12], 5'd1, OPC_LUI});
        prog.push_back(enc_i(a[11:0], 3'b000, 1, 1, OPC_OP_IMM));
        hi = b + 32'h800;
        prog.push_back({hi[31:12], 5'd2, OPC_LUI});
        prog.push_back(enc_i(b[11:0], 3'b000, 2, 2, OPC_OP_IMM));
        if (k <= K_SLTU) begin
            prog.push_back({(k == K_SUB || k == K_SRA) ? 7'b0100000 : 7'b0, 5'd2, 5'd1,
                            f3_of(k), 5'd3, OPC_OP});
        end else if (k <= K_SLTIU) begin
            imm = b[11:0];
            if (k == K_SLLI || k == K_SRLI) imm = {7'b0, b[4:0]};
            if (k == K_SRAI) imm = {7'b0100000, b[4:0]};
            prog.push_back(enc_i(imm, f3_of((k == K_ADDI) ? K_ADD : k - 9), 3, 1, OPC_OP_IMM));
        end else if (k == K_LUI || k == K_AUIPC) begin
            prog.push_back({b[31:12], 5'd3, (k == K_LUI) ? OPC_LUI : OPC_AUIPC});
        end else if (k == K_SWLW) begin
            prog.push_back({DATA_ADDR[11:5], 5'd2, 5'd0, 3'b010, DATA_ADDR[4:0], OPC_STORE});
            prog.push_back(enc_i(DATA_ADDR[11:0], 3'b010, 3, 0, OPC_LOAD));
        end else begin
            if (k == K_JAL) prog.push_back(enc_j(21'd8, 3));
            else if (k == K_JALR) prog.push_back(enc_i(12'd1, 3'b000, 3, 1, OPC_JALR));
            else prog.push_back(enc_b(13'd8, f3_of(k), 1, 2));
            prog.push_back(enc_i(12'd1, 3'b000, 3, 0, OPC_OP_IMM));  // skipped when taken
            if (k >= K_BEQ && k <= K_BGEU) prog.push_back(enc_i(12'd2, 3'b000, 3, 3, OPC_OP_IMM));
        end
        off = EXIT_ADDR - 32'(prog.size() * 4);
        prog.push_back(enc_j(off[20:0], 0));
        for (int j = 0; j < 2048; j++) begin
            u_mem.mem[j] = (j < prog.size()) ? prog[j] : {16'(j), ~16'(j)};
        end
    endtask

    task automatic add_row(string name, int kind, bit rnd, word_t a, word_t b);
        names.push_back(name);
        kinds.push_back(kind);
        rnds.push_back(rnd);
        opa.push_back(a);
        opb.push_back(b);
    endtask

    task automatic run_row(int i);
        word_t a, b, exp;
        int strobes_before;
        a = opa[i];
        b = opb[i];
        if (rnds[i]) begin
            a = rand_word();
            b = rand_word();
        end
        @(posedge clk);
        rst_n     <= 1'b0;
        exp_valid <= (kinds[i] == K_SWLW);
        exp_addr  <= DATA_ADDR;
        exp_data  <= b;
        load_program(kinds[i], a, b);  // core is parked at exit here
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        strobes_before = strobes;
        @(negedge clk);
        while (!exit_flag) @(negedge clk);
        exp = expect_x3(kinds[i], a, b);
        if (gp !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", names[i], exp, gp);
        end
        if (kinds[i] == K_SWLW && strobes != strobes_before + 1) begin
            errors++;
            $display("Mismatch %s strobes: expected 1, actual %0d", names[i],
                     strobes - strobes_before);
        end
        repeat (5) begin
            @(negedge clk);
            if (imem_addr !== EXIT_ADDR) begin
                errors++;
                $display("Mismatch %s imem_addr: expected %h, actual %h", names[i],
                         EXIT_ADDR, imem_addr);
            end
            if (dmem_wen !== 1'b0) begin
                errors++;
                $display("Mismatch %s dmem_wen: expected 0, actual %b", names[i], dmem_wen);
            end
        end
    endtask

    initial begin
        wait (n_rows > 0);
        #(n_rows * 40 * 100);
        $display("watchdog expired, exit was never reached");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        exp_valid = 1'b0;
        exp_addr  = '0;
        exp_data  = '0;
        add_row("add", K_ADD, 0, 32'd5, 32'd7);
        add_row("add_rnd", K_ADD, 1, 0, 0);
        add_row("sub", K_SUB, 0, 32'd3, 32'd10);
        add_row("and_rnd", K_AND, 1, 0, 0);
        add_row("or_rnd", K_OR, 1, 0, 0);
        add_row("xor_rnd", K_XOR, 1, 0, 0);
        add_row("sll", K_SLL, 0, 32'h1234_5678, 32'd4);
        add_row("srl", K_SRL, 0, 32'h8000_0000, 32'd31);
        add_row("sra_neg", K_SRA, 0, 32'h8000_0000, 32'd4);
        add_row("slt_neg", K_SLT, 0, -32'sd5, 32'd3);
        add_row("slt_pos", K_SLT, 0, 32'd3, -32'sd5);
        add_row("sltu", K_SLTU, 0, -32'sd5, 32'd3);
        add_row("addi_neg", K_ADDI, 0, 32'd100, 32'hffff_ffff);
        add_row("andi_rnd", K_ANDI, 1, 0, 0);
        add_row("ori_rnd", K_ORI, 1, 0, 0);
        add_row("xori_rnd", K_XORI, 1, 0, 0);
        add_row("slli", K_SLLI, 0, 32'h0000_00ff, 32'd12);
        add_row("srli", K_SRLI, 0, 32'hf000_0000, 32'd8);
        add_row("srai", K_SRAI, 0, 32'h8000_0010, 32'd3);
        add_row("slti", K_SLTI, 0, 32'hffff_ffff, 32'd0);
        add_row("sltiu", K_SLTIU, 0, 32'd5, 32'h0000_0fff);
        add_row("lui", K_LUI, 0, 0, 32'habcd_e123);
        add_row("auipc", K_AUIPC, 0, 0, 32'h1234_5000);
        add_row("beq_taken", K_BEQ, 0, 32'd7, 32'd7);
        add_row("beq_not", K_BEQ, 0, 32'd7, 32'd8);
        add_row("bne_taken", K_BNE, 0, 32'd1, 32'd2);
        add_row("bne_not", K_BNE, 0, 32'd5, 32'd5);
        add_row("blt_taken", K_BLT, 0, 32'hffff_ffff, 32'd1);
        add_row("blt_not", K_BLT, 0, 32'd1, 32'hffff_ffff);
        add_row("bge_taken", K_BGE, 0, 32'd1, 32'hffff_ffff);
        add_row("bge_not", K_BGE, 0, 32'hffff_ffff, 32'd1);
        add_row("bltu_taken", K_BLTU, 0, 32'd1, 32'hffff_ffff);
        add_row("bltu_not", K_BLTU, 0, 32'hffff_ffff, 32'd1);
        add_row("bgeu_taken", K_BGEU, 0, 32'hffff_ffff, 32'd1);
        add_row("bgeu_not", K_BGEU, 0, 32'd1, 32'hffff_ffff);
        add_row("bgeu_rnd", K_BGEU, 1, 0, 0);
        add_row("sw_lw", K_SWLW, 0, 0, 32'hdead_beef);
        add_row("sw_lw_rnd", K_SWLW, 1, 0, 0);
        add_row("jal", K_JAL, 0, 0, 0);
        add_row("jalr_odd", K_JALR, 0, 32'd24, 0);  // target 25 lands on 24
        n_rows = names.size();
        for (int i = 0; i < n_rows; i++) run_row(i);
        $display("rows %0d, core errors %0d, memory errors %0d", n_rows, errors, mem_errs);
        if (errors == 0 && mem_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_sequencer.sv
hdl/rv_core.sv
test/tb_mem.sv
test/tb_core.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_core -f list.f -o tb_core_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_core_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
    exit 0
else
    exit 1
fi
